// File: core.f
+incdir+common
common/core_pkg.sv
src/pipeline/stage_fetch.sv
src/pipeline/stage_decode.sv
src/pipeline/stage_execute.sv
src/pipeline/stage_memory.sv
src/pipeline/forward/main_forwarder.sv
src/core.sv
testbench/tb_clock.sv
testbench/tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  ?= TEST RESULT: PASS

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard common/*.sv common/*.svh src/*.sv src/pipeline/*.sv \
          src/pipeline/forward/*.sv testbench/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_core.sv
`include "core_consts.svh"

module tb_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROM_WORDS = 128;
    localparam int GAP       = 4;            // Nops between the two program copies
    localparam int CLK_NS    = 8;
    localparam int MARGIN    = 64;
    localparam logic [1:0] EV_STORE = 2'd0;
    localparam logic [1:0] EV_LOAD  = 2'd1;
    localparam logic [1:0] EV_ERROR = 2'd2;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;
        logic [31:0] data;
    } mem_event_t;

    logic        clk;
    logic        arst_n;
    logic        ibusy = 1'b0;
    logic        dwe;
    logic        dre;
    logic        address_error;
    logic [31:0] iaddr;
    logic [31:0] idata;
    logic [31:0] daddr;
    logic [31:0] dwdata;
    logic [31:0] drdata;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] ram [64];
    mem_event_t  expected [$];
    mem_event_t  ev;
    logic [1:0]  kind_now;
    integer      seed;
    int          emit_at;
    int          prog_len;
    int          watchdog_ns;
    int          busy_cycles  = 0;
    logic        random_phase = 1'b0;
    logic        held_busy    = 1'b0;
    logic        just_reset   = 1'b0;
    logic [31:0] held_iaddr;

    tb_clock clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    core dut0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .iaddr         (iaddr),
        .idata         (idata),
        .ibusy         (ibusy),
        .daddr         (daddr),
        .dwdata        (dwdata),
        .drdata        (drdata),
        .dwe           (dwe),
        .dre           (dre),
        .address_error (address_error)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Memory models
    // ~~~~~~~~~~~~~~~~~~~~
    assign idata  = (iaddr < 32'(ROM_WORDS * 4)) ? rom[iaddr[8:2]] : 32'h0;   // Past the end is nop
    assign drdata = ram[daddr[7:2]];

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hd00d_0000 + 32'(idx) * 32'h0001_0101;
    endfunction

    function automatic logic [31:0] r_type(input int rd, input int rs, input int rt,
                                           input logic [5:0] fn);
        return {`OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input int rt, input int rs,
                                           input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[emit_at] = word;
        emit_at++;
    endtask

    task automatic write_program();
        emit(i_type(`OP_LUI, 1, 0, 16'h1234));
        emit(i_type(`OP_ORI, 1, 1, 16'h5678));           // Distance one chain
        emit(i_type(`OP_ADDIU, 2, 1, 16'hffff));
        emit(r_type(3, 1, 2, `FN_ADDU));
        emit(r_type(4, 3, 1, `FN_SUBU));
        emit(r_type(5, 4, 3, `FN_AND));
        emit(r_type(6, 5, 1, `FN_OR));
        emit(i_type(`OP_ADDIU, 10, 0, 16'hfffb));
        emit(r_type(7, 10, 6, `FN_SLT));                 // Signed compare, true
        emit(i_type(`OP_ADDIU, 8, 0, 16'h0040));         // Store base
        emit(i_type(`OP_SW, 3, 8, 16'h0000));
        emit(i_type(`OP_SW, 7, 8, 16'h0004));
        emit(r_type(9, 6, 10, `FN_SLT));
        emit(i_type(`OP_SW, 9, 8, 16'h0008));
        emit(i_type(`OP_ADDIU, 11, 0, 16'h0011));
        emit(32'h0);
        emit(r_type(12, 11, 11, `FN_ADDU));              // Distance two
        emit(32'h0);
        emit(32'h0);
        emit(i_type(`OP_SW, 12, 8, 16'h000c));           // Distance three
        emit(i_type(`OP_LW, 13, 0, 16'h0080));
        emit(32'h0);
        emit(r_type(14, 13, 1, `FN_ADDU));               // Load used two later
        emit(i_type(`OP_SW, 13, 8, 16'h0010));
        emit(i_type(`OP_SW, 14, 8, 16'h0014));
        emit(i_type(`OP_LW, 15, 8, 16'h0004));
        emit(32'h0);
        emit(i_type(`OP_SW, 15, 8, 16'h0018));           // Store of loaded data
        emit(i_type(`OP_ADDIU, 0, 0, 16'h0077));
        emit(r_type(0, 1, 1, `FN_ADDU));
        emit(i_type(`OP_SW, 0, 8, 16'h001c));            // Must store zero
        emit(i_type(`OP_SW, 1, 8, 16'h0002));            // Misaligned
        emit(i_type(`OP_SW, 6, 8, 16'h0020));
        emit(i_type(`OP_LW, 14, 8, 16'h0001));           // Misaligned load
        emit(i_type(`OP_SW, 5, 8, 16'h0024));
        emit(i_type(`OP_SW, 14, 8, 16'h0028));           // r14 keeps its old value
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic expect_event(input logic [1:0] kind, input logic [31:0] addr,
                                input logic [31:0] data);
        mem_event_t e;
        e.kind = kind;
        e.addr = addr;
        e.data = data;
        expected.push_back(e);
    endtask

    task automatic run_reference();
        logic [31:0] regs [32];
        logic [31:0] mem [64];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] result;
        logic        writes;
        int          dest;
        for (int r = 0; r < 32; r++) regs[r] = 32'h0;
        for (int i = 0; i < 64; i++) mem[i] = fill_word(i);
        for (int k = 0; k < emit_at; k++) begin
            w      = rom[k];
            a      = regs[w[25:21]];
            b      = regs[w[20:16]];
            addr   = a + {{16{w[15]}}, w[15:0]};
            writes = 1'b1;
            dest   = int'(w[20:16]);
            result = 32'h0;
            case (w[31:26])
                `OP_SPECIAL: begin
                    dest = int'(w[15:11]);
                    case (w[5:0])
                        `FN_ADDU: result = a + b;
                        `FN_SUBU: result = a - b;
                        `FN_AND:  result = a & b;
                        `FN_OR:   result = a | b;
                        `FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:  writes = 1'b0;
                    endcase
                end
                `OP_ADDIU: result = addr;
                `OP_ORI:   result = a | {16'h0, w[15:0]};
                `OP_LUI:   result = {w[15:0], 16'h0};
                `OP_LW: begin
                    writes = (addr[1:0] == 2'b00);
                    result = mem[addr[7:2]];
                    expect_event(writes ? EV_LOAD : EV_ERROR, addr, 32'h0);
                end
                `OP_SW: begin
                    writes = 1'b0;
                    if (addr[1:0] == 2'b00) begin
                        mem[addr[7:2]] = b;
                        expect_event(EV_STORE, addr, b);
                    end else begin
                        expect_event(EV_ERROR, addr, 32'h0);
                    end
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != 0) regs[dest] = result;
        end
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "data port mismatch");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus and checks
    // ~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (arst_n && iaddr >= 32'((prog_len + GAP) * 4)) random_phase <= 1'b1;
        if (random_phase) ibusy <= (($random(seed) & 3) == 0);   // About one cycle in four
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            assert (!dwe && !dre && !address_error)
                else report_mismatch("data port strobe high during reset");
            assert (iaddr == `RESET_PC)
                else report_mismatch($sformatf("iaddr %h during reset", iaddr));
            just_reset = 1'b1;
        end else begin
            if (just_reset) begin
                assert (iaddr == `RESET_PC)
                    else report_mismatch($sformatf("iaddr %h right after reset", iaddr));
            end
            just_reset = 1'b0;
            if (held_busy) begin
                assert (iaddr == held_iaddr)
                    else report_mismatch($sformatf("iaddr moved from %h to %h under ibusy",
                                                   held_iaddr, iaddr));
            end
            held_busy  = ibusy;
            held_iaddr = iaddr;
            if (ibusy) busy_cycles++;
            assert (!(dwe && address_error)) else report_mismatch("dwe with address_error");
            assert (!(dwe && dre)) else report_mismatch("dwe and dre together");
            if (dwe || dre || address_error) begin
                if (expected.size() == 0) begin
                    report_failure("The core made a data access that the program does not have");
                end
                ev       = expected.pop_front();
                kind_now = dwe ? EV_STORE : (dre ? EV_LOAD : EV_ERROR);
                assert (kind_now == ev.kind)
                    else report_mismatch($sformatf("access kind %0d, expected %0d",
                                                   kind_now, ev.kind));
                assert (daddr == ev.addr)
                    else report_mismatch($sformatf("daddr %h, expected %h", daddr, ev.addr));
                if (dwe) begin
                    assert (dwdata == ev.data)
                        else report_mismatch($sformatf("dwdata %h at %h, expected %h",
                                                       dwdata, daddr, ev.data));
                    ram[daddr[7:2]] <= dwdata;
                end
            end
        end
    end

    initial begin
        seed    = 32'hc668_c0f2;
        emit_at = 0;
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = 32'h0;
        write_program();
        prog_len = emit_at;
        emit_at  = prog_len + GAP;
        write_program();                      // Second copy runs with random ibusy
        for (int i = 0; i < 64; i++) ram[i] <= fill_word(i);
        run_reference();
        watchdog_ns = (prog_len * 2 * 4 + MARGIN) * CLK_NS;
        @(posedge arst_n);
        while (expected.size() > 0) @(negedge clk);
        repeat (4) @(negedge clk);            // Pipeline depth, catches stray accesses
        if (busy_cycles > 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("ibusy never went high, so the second run was not exercised");
            $display("TEST RESULT: FAIL");
            $fatal(1, "no ibusy cycles");
        end
    end

    initial begin
        @(posedge arst_n);
        #(watchdog_ns);
        $display("Watchdog expired: the program did not finish within %0d ns", watchdog_ns);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog");
    end

endmodule

// File: testbench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_NS      = 4;         // 8 ns period
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: src/core.sv
`include "core_consts.svh"

module core (
    input  logic                clk,
    input  logic                arst_n,
    output logic [`DATA_W-1:0]  iaddr,
    input  logic [`DATA_W-1:0]  idata,
    input  logic                ibusy,
    output logic [`DATA_W-1:0]  daddr,
    output logic [`DATA_W-1:0]  dwdata,
    input  logic [`DATA_W-1:0]  drdata,
    output logic                dwe,
    output logic                dre,
    output logic                address_error
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage records
    // ~~~~~~~~~~~~~~~~~~~~
    core_pkg::fetch_rec_t      fetch_rec;
    core_pkg::decode_rec_t     decode_rec;
    core_pkg::execute_rec_t    execute_rec;
    core_pkg::write_back_rec_t write_back_rec;

    core_pkg::forward_sel_t    forward_rs;
    core_pkg::forward_sel_t    forward_rt;

    stage_fetch unit_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .ibusy      (ibusy),
        .idata      (idata),
        .iaddr      (iaddr),
        .fetch      (fetch_rec)
    );

    stage_decode unit_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch      (fetch_rec),
        .write_back (write_back_rec),      // Register file write port
        .decode     (decode_rec)
    );

    main_forwarder unit_forwarder (
        .decode     (decode_rec),
        .execute    (execute_rec),
        .write_back (write_back_rec),
        .forward_rs (forward_rs),
        .forward_rt (forward_rt)
    );

    stage_execute unit_execute (
        .clk           (clk),
        .arst_n        (arst_n),
        .decode        (decode_rec),
        .forward_rs    (forward_rs),
        .forward_rt    (forward_rt),
        .memory_result (execute_rec.alu_result),
        .write_back    (write_back_rec),
        .execute       (execute_rec)
    );

    stage_memory unit_memory (
        .clk           (clk),
        .arst_n        (arst_n),
        .execute       (execute_rec),
        .drdata        (drdata),
        .daddr         (daddr),
        .dwdata        (dwdata),
        .dwe           (dwe),
        .dre           (dre),
        .address_error (address_error),
        .write_back    (write_back_rec)
    );

endmodule

// File: src/pipeline/forward/main_forwarder.sv
module main_forwarder (
    input  core_pkg::decode_rec_t       decode,
    input  core_pkg::execute_rec_t      execute,
    input  core_pkg::write_back_rec_t   write_back,
    output core_pkg::forward_sel_t      forward_rs,
    output core_pkg::forward_sel_t      forward_rt
);

    logic memory_hit_ok;
    logic write_back_hit_ok;

    // A load result is not ready one stage ahead
    assign memory_hit_ok = execute.valid && execute.control.write_reg
                           && !execute.control.mem_read;

    assign write_back_hit_ok = write_back.valid && write_back.write_reg;

    function automatic core_pkg::forward_sel_t select(input core_pkg::reg_idx_t src);
        core_pkg::forward_sel_t sel;
        if (src == '0) begin
            sel = core_pkg::fwd_none;          // Register 0 never forwards
        end else if (memory_hit_ok && execute.dest_reg == src) begin
            sel = core_pkg::fwd_from_memory;   // Newest value wins
        end else if (write_back_hit_ok && write_back.dest_reg == src) begin
            sel = core_pkg::fwd_from_write_back;
        end else begin
            sel = core_pkg::fwd_none;
        end
        return sel;
    endfunction

    assign forward_rs = select(decode.rs);
    assign forward_rt = select(decode.rt);

endmodule

// File: src/pipeline/stage_memory.sv
`include "core_consts.svh"

module stage_memory (
    input  logic                        clk,
    input  logic                        arst_n,
    input  core_pkg::execute_rec_t      execute,
    input  logic [`DATA_W-1:0]          drdata,
    output logic [`DATA_W-1:0]          daddr,
    output logic [`DATA_W-1:0]          dwdata,
    output logic                        dwe,
    output logic                        dre,
    output logic                        address_error,
    output core_pkg::write_back_rec_t   write_back
);

    logic misaligned;
    logic load;
    logic store;

    assign load       = execute.valid && execute.control.mem_read;
    assign store      = execute.valid && execute.control.mem_write;
    assign misaligned = |execute.alu_result[1:0];

    assign daddr         = execute.alu_result;
    assign dwdata        = execute.store_data;
    assign dwe           = store && !misaligned;
    assign dre           = load && !misaligned;
    assign address_error = (load || store) && misaligned;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            write_back <= '0;
        end else begin
            write_back.valid     <= execute.valid;
            write_back.write_reg <= execute.valid && execute.control.write_reg
                                    && !(load && misaligned);  // Bad load writes nothing
            write_back.dest_reg  <= execute.dest_reg;
            write_back.dest_reg_data <= execute.control.mem_read ? drdata
                                                                 : execute.alu_result;
        end
    end

endmodule

// File: src/pipeline/stage_execute.sv
`include "core_consts.svh"

module stage_execute (
    input  logic                        clk,
    input  logic                        arst_n,
    input  core_pkg::decode_rec_t       decode,
    input  core_pkg::forward_sel_t      forward_rs,
    input  core_pkg::forward_sel_t      forward_rt,
    input  logic [`DATA_W-1:0]          memory_result,
    input  core_pkg::write_back_rec_t   write_back,
    output core_pkg::execute_rec_t      execute
);

    logic [`DATA_W-1:0] rs_value;
    logic [`DATA_W-1:0] rt_value;
    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] alu_result;

    function automatic logic [`DATA_W-1:0] pick(
        input core_pkg::forward_sel_t sel,
        input logic [`DATA_W-1:0]     reg_value
    );
        logic [`DATA_W-1:0] value;
        case (sel)
            core_pkg::fwd_from_memory:     value = memory_result;
            core_pkg::fwd_from_write_back: value = write_back.dest_reg_data;
            default:                       value = reg_value;
        endcase
        return value;
    endfunction

    assign rs_value = pick(forward_rs, decode.rs_data);
    assign rt_value = pick(forward_rt, decode.rt_data);

    assign op_a = rs_value;
    assign op_b = decode.control.use_imm ? decode.immediate : rt_value;

    // ~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (decode.control.alu_op)
            core_pkg::alu_add: alu_result = op_a + op_b;
            core_pkg::alu_sub: alu_result = op_a - op_b;
            core_pkg::alu_and: alu_result = op_a & op_b;
            core_pkg::alu_or:  alu_result = op_a | op_b;
            core_pkg::alu_slt: alu_result = {{(`DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            core_pkg::alu_lui: alu_result = op_b << 16;
            default:           alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            execute <= '0;
        end else begin
            execute.valid      <= decode.valid;
            execute.control    <= decode.control;
            execute.dest_reg   <= decode.dest_reg;
            execute.alu_result <= alu_result;
            execute.store_data <= rt_value;     // Store data after forwarding
        end
    end

endmodule

// File: src/pipeline/stage_decode.sv
`include "core_consts.svh"

module stage_decode (
    input  logic                        clk,
    input  logic                        arst_n,
    input  core_pkg::fetch_rec_t        fetch,
    input  core_pkg::write_back_rec_t   write_back,
    output core_pkg::decode_rec_t       decode
);

    logic [`DATA_W-1:0] reg_file [`REG_N];

    logic [5:0]         opcode;
    logic [5:0]         funct;
    core_pkg::reg_idx_t rs;
    core_pkg::reg_idx_t rt;
    core_pkg::reg_idx_t rd;
    logic [15:0]        imm;
    core_pkg::control_t control;
    logic               sign_ext;
    logic               dest_is_rd;
    logic [`DATA_W-1:0] immediate;
    logic               wb_write;

    assign opcode = fetch.instruction[31:26];
    assign rs     = fetch.instruction[25:21];
    assign rt     = fetch.instruction[20:16];
    assign rd     = fetch.instruction[15:11];
    assign funct  = fetch.instruction[5:0];
    assign imm    = fetch.instruction[15:0];

    assign wb_write = write_back.valid && write_back.write_reg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Control decode
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        control    = '0;                       // Anything unknown is a nop
        sign_ext   = 1'b0;
        dest_is_rd = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                dest_is_rd        = 1'b1;
                control.write_reg = 1'b1;
                case (funct)
                    `FN_ADDU: control.alu_op = core_pkg::alu_add;
                    `FN_SUBU: control.alu_op = core_pkg::alu_sub;
                    `FN_AND:  control.alu_op = core_pkg::alu_and;
                    `FN_OR:   control.alu_op = core_pkg::alu_or;
                    `FN_SLT:  control.alu_op = core_pkg::alu_slt;
                    default:  control.write_reg = 1'b0;
                endcase
            end
            `OP_ADDIU: begin
                control.write_reg = 1'b1;
                control.use_imm   = 1'b1;
                sign_ext          = 1'b1;
            end
            `OP_ORI: begin
                control.write_reg = 1'b1;
                control.use_imm   = 1'b1;
                control.alu_op    = core_pkg::alu_or;
            end
            `OP_LUI: begin
                control.write_reg = 1'b1;
                control.use_imm   = 1'b1;
                control.alu_op    = core_pkg::alu_lui;
            end
            `OP_LW: begin
                control.write_reg = 1'b1;
                control.mem_read  = 1'b1;
                control.use_imm   = 1'b1;
                sign_ext          = 1'b1;
            end
            `OP_SW: begin
                control.mem_write = 1'b1;
                control.use_imm   = 1'b1;
                sign_ext          = 1'b1;
            end
            default: ;
        endcase
    end

    assign immediate = sign_ext ? {{(`DATA_W-16){imm[15]}}, imm} : {{(`DATA_W-16){1'b0}}, imm};

    // ~~~~~~~~~~~~~~~~~~~~
    // Register file
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [`DATA_W-1:0] read_reg(input core_pkg::reg_idx_t idx);
        logic [`DATA_W-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (wb_write && write_back.dest_reg == idx) begin
            value = write_back.dest_reg_data;  // Same-cycle write seen here
        end else begin
            value = reg_file[idx];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (wb_write && write_back.dest_reg != '0) begin
            reg_file[write_back.dest_reg] <= write_back.dest_reg_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decode <= '0;
        end else begin
            decode.valid     <= fetch.valid;
            decode.control   <= control;
            decode.rs        <= rs;
            decode.rt        <= rt;
            decode.dest_reg  <= dest_is_rd ? rd : rt;
            decode.rs_data   <= read_reg(rs);
            decode.rt_data   <= read_reg(rt);
            decode.immediate <= immediate;
        end
    end

endmodule

// File: src/pipeline/stage_fetch.sv
`include "core_consts.svh"

module stage_fetch (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ibusy,
    input  logic [`DATA_W-1:0]     idata,
    output logic [`DATA_W-1:0]     iaddr,
    output core_pkg::fetch_rec_t   fetch
);

    logic [`DATA_W-1:0] pc;

    assign iaddr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else if (!ibusy) begin
            pc <= pc + `DATA_W'(4);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch <= '0;
        end else if (ibusy) begin
            fetch <= '0;                       // Bubble, pc is held
        end else begin
            fetch.valid       <= 1'b1;
            fetch.instruction <= idata;
            fetch.pc          <= pc;
        end
    end

endmodule

// File: common/core_pkg.sv
`include "core_consts.svh"

package core_pkg;

    typedef logic [$clog2(`REG_N)-1:0] reg_idx_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Control word
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4,
        alu_lui = 3'd5                      // Operand b shifted up by 16
    } alu_op_t;

    typedef struct packed {
        logic    write_reg;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;                   // Operand b from the immediate
        alu_op_t alu_op;
    } control_t;

    typedef enum logic [1:0] {
        fwd_none            = 2'd0,         // Value read in decode
        fwd_from_memory     = 2'd1,         // ALU result one stage ahead
        fwd_from_write_back = 2'd2
    } forward_sel_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage records
    // ~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] instruction;
        logic [`DATA_W-1:0] pc;
    } fetch_rec_t;

    typedef struct packed {
        logic               valid;
        control_t           control;
        reg_idx_t           rs;
        reg_idx_t           rt;
        reg_idx_t           dest_reg;
        logic [`DATA_W-1:0] rs_data;
        logic [`DATA_W-1:0] rt_data;
        logic [`DATA_W-1:0] immediate;      // Already extended
    } decode_rec_t;

    typedef struct packed {
        logic               valid;
        control_t           control;
        reg_idx_t           dest_reg;
        logic [`DATA_W-1:0] alu_result;     // Also the data address
        logic [`DATA_W-1:0] store_data;
    } execute_rec_t;

    typedef struct packed {
        logic               valid;
        logic               write_reg;
        reg_idx_t           dest_reg;
        logic [`DATA_W-1:0] dest_reg_data;
    } write_back_rec_t;

endpackage

// File: common/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Datapath sizes
// ~~~~~~~~~~~~~~~~~~~~
`define DATA_W      32
`define REG_N       32              // Register 0 always reads zero
`define RESET_PC    32'h0000_0000

// ~~~~~~~~~~~~~~~~~~~~
// Opcodes, bits 31:26
// ~~~~~~~~~~~~~~~~~~~~
`define OP_SPECIAL  6'h00           // Register operations, selected by funct
`define OP_ADDIU    6'h09
`define OP_ORI      6'h0d
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

// ~~~~~~~~~~~~~~~~~~~~
// Funct codes, bits 5:0
// ~~~~~~~~~~~~~~~~~~~~
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

// A nop is sll r0,r0,0 and falls through as an unknown funct

`endif
